//--- adma_controller.f
source/adma_pkg.sv
source/descriptor_sequencer.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/adma_controller.sv
tests/adma_controller_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = adma_controller_tb
FILE_LIST = adma_controller.f
BUILD_DIR = build
LOG       = $(BUILD_DIR)/simulation.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/adma_controller_tb.sv
`timescale 1ns/1ps

module adma_controller_tb;

  import adma_pkg::*;

  localparam int    MEMORY_WORDS    = 16384;
  localparam int    CHAIN_LINES     = 4;
  localparam int    LINE_WORDS_MAX  = 300;
  localparam int    TOTAL_WORDS     = (2 * CHAIN_LINES + 4) * LINE_WORDS_MAX;
  localparam int    WATCHDOG_CYCLES = TOTAL_WORDS * 16 + 5000;
  localparam addr_t TABLE_A         = 32'h0000_0100;
  localparam addr_t TABLE_B         = 32'h0000_0400;

  logic       clock;
  logic       reset;
  logic       dma_enable;
  logic       direction;
  logic       data_present;
  logic       command_complete;
  addr_t      descriptor_base;
  logic       interrupt_clear;
  logic [1:0] interrupts;

  // Bus model inputs start low before the first falling edge
  addr_t      araddr;
  logic [7:0] arlen;
  logic       arvalid;
  logic       arready = 1'b0;
  word_t      rdata = '0;
  logic       rvalid = 1'b0;
  logic       rlast = 1'b0;
  logic       rready;
  addr_t      awaddr;
  logic [7:0] awlen;
  logic       awvalid;
  logic       awready = 1'b0;
  word_t      wdata;
  logic       wvalid;
  logic       wready = 1'b0;
  logic       wlast;
  logic       bvalid = 1'b0;
  logic       bready;
  logic       fifo_write_valid;
  word_t      fifo_write_data;
  logic       fifo_word_written = 1'b0;
  word_t      fifo_read_data = '0;
  logic       fifo_read_ready;
  logic       start_write;
  logic       block_done = 1'b0;

  int    seed = 89739;
  int    check_count = 0;
  int    error_count = 0;
  word_t memory [0:MEMORY_WORDS-1];
  word_t model_memory [0:MEMORY_WORDS-1];

  // Slave and card model state
  addr_t rd_addr = '0;
  int    rd_left = 0;
  bit    rd_active = 1'b0;
  addr_t wr_addr = '0;
  int    wr_left = 0;
  bit    wr_active = 1'b0;
  bit    resp_pending = 1'b0;
  word_t card_source[$];
  word_t card_fifo[$];
  word_t pushed_word = '0;
  word_t collected[$];
  word_t expected_fifo[$];
  int    serial_delay = 0;
  bit    block_waiting = 1'b0;
  int    start_write_count = 0;
  int    expected_blocks = 0;
  addr_t next_region = 32'h0000_1000;

  adma_controller i_adma_controller (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Timeout: the DMA tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI slave, card FIFO and serializer models
  ////////////////////////////////////////////////////////////////////////////

  // Handshakes are taken on the rising edge
  always @(posedge clock) begin
    if (arvalid && arready) begin
      check_value(word_t'(int'(arlen) < BURST_BEATS), 1, "read burst length");
      rd_addr   = araddr;
      rd_left   = int'(arlen) + 1;
      rd_active = 1'b1;
    end
    if (rvalid && rready) begin
      rd_addr = rd_addr + 4;
      rd_left--;
      if (rd_left == 0) rd_active = 1'b0;
    end
    if (awvalid && awready) begin
      check_value(word_t'(int'(awlen) < BURST_BEATS), 1, "write burst length");
      wr_addr   = awaddr;
      wr_left   = int'(awlen) + 1;
      wr_active = 1'b1;
    end
    if (wvalid && wready) begin
      check_value(word_t'(wlast), word_t'(wr_left == 1), "wlast on the final beat");
      memory[wr_addr[15:2]] = wdata;
      wr_addr = wr_addr + 4;
      wr_left--;
      if (wr_left == 0) begin
        wr_active    = 1'b0;
        resp_pending = 1'b1;
      end
    end
    if (bvalid && bready) resp_pending = 1'b0;
    // Pop before push so the popped word is the one that was on wdata
    if (fifo_read_ready) begin
      check_value(word_t'(card_fifo.size() != 0), 1, "card FIFO holds a word when popped");
      if (card_fifo.size() != 0) card_fifo.delete(0);
    end
    if (fifo_word_written) card_fifo.push_back(pushed_word);
    if (block_done) block_waiting = 1'b0;
    if (fifo_write_valid) begin
      check_value(word_t'(block_waiting), 0, "FIFO write while a block is pending");
      collected.push_back(fifo_write_data);
    end
    if (start_write) begin
      start_write_count++;
      block_waiting = 1'b1;
      serial_delay  = 1 + int'($unsigned($random(seed)) % 6);
    end
  end

  // Responses change on the falling edge
  always @(negedge clock) begin
    arready = !rd_active && (($random(seed) & 3) != 0);
    rvalid  = rd_active && (($random(seed) & 3) != 0);
    rdata   = memory[rd_addr[15:2]];
    rlast   = rd_active && (rd_left == 1);
    awready = !wr_active && !resp_pending && (($random(seed) & 3) != 0);
    wready  = wr_active && (($random(seed) & 3) != 0);
    bvalid  = resp_pending && (bvalid || (($random(seed) & 1) != 0));
    fifo_word_written = 1'b0;
    if (card_source.size() != 0 && (($random(seed) & 1) != 0)) begin
      fifo_word_written = 1'b1;
      pushed_word       = card_source.pop_front();
    end
    fifo_read_data = (card_fifo.size() != 0) ? card_fifo[0] : '0;
    block_done = 1'b0;
    if (serial_delay > 0) begin
      serial_delay--;
      if (serial_delay == 0) block_done = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table building and expected results
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_memory();
    int i;
    for (i = 0; i < MEMORY_WORDS; i++) begin
      memory[i]       = (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
      model_memory[i] = memory[i];
    end
  endtask

  function automatic word_t make_attribute(input int words, input logic [1:0] act,
                                           input bit last, input bit valid);
    return (word_t'(words) << 18) | (word_t'(act) << ACT_LSB) |
           (word_t'(last) << END_BIT) | (word_t'(valid) << VALID_BIT);
  endfunction

  task automatic put_descriptor(input addr_t line_addr, input word_t attribute,
                                input addr_t address);
    int index;
    index = int'(line_addr[15:2]);
    memory[index]           = attribute;
    memory[index + 1]       = address;
    model_memory[index]     = attribute;
    model_memory[index + 1] = address;
  endtask

  // Memory to card expects the region's words in the FIFO, card to memory lands card words
  task automatic add_region(input addr_t region, input int words, input bit to_card);
    int    i;
    int    index;
    word_t value;
    index = int'(region[15:2]);
    for (i = 0; i < words; i++) begin
      if (to_card) begin
        expected_fifo.push_back(model_memory[index + i]);
      end else begin
        value = $random(seed);
        card_source.push_back(value);
        model_memory[index + i] = value;
      end
    end
    if (to_card) expected_blocks += (words + BLOCK_WORDS - 1) / BLOCK_WORDS;
  endtask

  task automatic add_tran_line(input addr_t line_addr, input int words, input bit last,
                               input bit to_card);
    addr_t region;
    region      = next_region;
    next_region = next_region + addr_t'(words * 4 + 16);
    put_descriptor(line_addr, make_attribute(words, ACT_TRAN, last, 1'b1), region);
    add_region(region, words, to_card);
  endtask

  task automatic pick_words(output int words);
    words = 1 + int'($unsigned($random(seed)) % LINE_WORDS_MAX);
  endtask

  task automatic build_chain(input addr_t table_addr, input int lines, input bit to_card);
    int i;
    int words;
    for (i = 0; i < lines; i++) begin
      pick_words(words);
      // At least one line spans more than one card block
      if (i == 0 && words <= BLOCK_WORDS) words = words + BLOCK_WORDS;
      add_tran_line(table_addr + addr_t'(i * DESCRIPTOR_BYTES), words, i == lines - 1, to_card);
    end
  endtask

  task automatic begin_test();
    collected.delete();
    expected_fifo.delete();
    start_write_count = 0;
    expected_blocks   = 0;
    next_region       = 32'h0000_1000;
  endtask

  task automatic compare_memory();
    int i;
    int mismatches;
    mismatches = 0;
    for (i = 0; i < MEMORY_WORDS; i++) begin
      if (memory[i] !== model_memory[i]) mismatches++;
    end
    check_value(word_t'(mismatches), 0, "memory words differing from the model");
  endtask

  task automatic run_table(input addr_t base, input logic dir, input logic [1:0] expected_irq);
    int i;
    @(negedge clock);
    direction        = dir;
    dma_enable       = 1'b1;
    data_present     = 1'b1;
    descriptor_base  = base;
    command_complete = 1'b1;
    @(negedge clock);
    command_complete = 1'b0;
    while (interrupts == 2'b00) @(negedge clock);
    check_value(word_t'(interrupts), word_t'(expected_irq), "interrupts at end of table");
    check_value(word_t'(collected.size()), word_t'(expected_fifo.size()), "FIFO word count");
    for (i = 0; i < collected.size() && i < expected_fifo.size(); i++) begin
      check_value(collected[i], expected_fifo[i], "FIFO word");
    end
    check_value(word_t'(start_write_count), word_t'(expected_blocks), "start_write pulses");
    check_value(word_t'(card_source.size() + card_fifo.size()), 0, "card words left over");
    compare_memory();
    interrupt_clear = 1'b1;
    @(negedge clock);
    interrupt_clear = 1'b0;
    check_value(word_t'(interrupts), 0, "interrupts after clear");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int words;
    reset            = 1'b0;
    dma_enable       = 1'b0;
    direction        = 1'b0;
    data_present     = 1'b0;
    command_complete = 1'b0;
    descriptor_base  = '0;
    interrupt_clear  = 1'b0;
    fill_memory();
    repeat (8) @(negedge clock);
    reset = 1'b1;

    // Memory to card over a chain of tran lines
    @(posedge clock);
    begin_test();
    build_chain(TABLE_A, CHAIN_LINES, 1'b1);
    run_table(TABLE_A, 1'b0, 2'b01);

    // Card to memory
    @(posedge clock);
    begin_test();
    build_chain(TABLE_A, CHAIN_LINES, 1'b0);
    run_table(TABLE_A, 1'b1, 2'b01);

    // Nop lines and a link into a second table, the line after the link is never read
    @(posedge clock);
    begin_test();
    put_descriptor(TABLE_A, make_attribute(7, ACT_NOP, 1'b0, 1'b1), 32'h0000_2000);
    pick_words(words);
    add_tran_line(TABLE_A + 8, words, 1'b0, 1'b1);
    put_descriptor(TABLE_A + 16, make_attribute(0, ACT_LINK, 1'b0, 1'b1), TABLE_B);
    put_descriptor(TABLE_A + 24, make_attribute(20, ACT_TRAN, 1'b1, 1'b1), next_region);
    pick_words(words);
    add_tran_line(TABLE_B, words, 1'b0, 1'b1);
    put_descriptor(TABLE_B + 8, make_attribute(3, ACT_NOP, 1'b0, 1'b1), 32'h0000_3000);
    pick_words(words);
    add_tran_line(TABLE_B + 16, words, 1'b1, 1'b1);
    run_table(TABLE_A, 1'b0, 2'b01);

    // Invalid first line
    @(posedge clock);
    begin_test();
    put_descriptor(TABLE_A, make_attribute(40, ACT_TRAN, 1'b1, 1'b0), 32'h0000_1000);
    run_table(TABLE_A, 1'b0, 2'b10);

    repeat (4) @(negedge clock);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- source/adma_controller.sv
`timescale 1ns/1ps

module adma_controller (
  input  logic            clock,
  input  logic            reset,
  // Host controls
  input  logic            dma_enable,
  input  logic            direction,
  input  logic            data_present,
  input  logic            command_complete,
  input  adma_pkg::addr_t descriptor_base,
  input  logic            interrupt_clear,
  output logic [1:0]      interrupts,
  // AXI read
  output adma_pkg::addr_t araddr,
  output logic [7:0]      arlen,
  output logic            arvalid,
  input  logic            arready,
  input  adma_pkg::word_t rdata,
  input  logic            rvalid,
  input  logic            rlast,
  output logic            rready,
  // AXI write
  output adma_pkg::addr_t awaddr,
  output logic [7:0]      awlen,
  output logic            awvalid,
  input  logic            awready,
  output adma_pkg::word_t wdata,
  output logic            wvalid,
  input  logic            wready,
  output logic            wlast,
  input  logic            bvalid,
  output logic            bready,
  // Card-side FIFO and serializer
  output logic            fifo_write_valid,
  output adma_pkg::word_t fifo_write_data,
  input  logic            fifo_word_written,
  input  adma_pkg::word_t fifo_read_data,
  output logic            fifo_read_ready,
  output logic            start_write,
  input  logic            block_done
);

  import adma_pkg::*;

  logic        read_start;
  addr_t       read_address;
  word_count_t read_words;
  logic        read_to_fifo;
  logic        read_word_valid;
  word_t       read_word;
  logic        read_done;
  logic        write_start;
  addr_t       write_address;
  word_count_t write_words;
  logic        write_done;

  descriptor_sequencer i_descriptor_sequencer (
    .clock            (clock),
    .reset            (reset),
    .dma_enable       (dma_enable),
    .direction        (direction),
    .data_present     (data_present),
    .command_complete (command_complete),
    .interrupt_clear  (interrupt_clear),
    .descriptor_base  (descriptor_base),
    .read_word_valid  (read_word_valid),
    .read_word        (read_word),
    .read_done        (read_done),
    .write_done       (write_done),
    .read_start       (read_start),
    .read_address     (read_address),
    .read_words       (read_words),
    .read_to_fifo     (read_to_fifo),
    .write_start      (write_start),
    .write_address    (write_address),
    .write_words      (write_words),
    .interrupts       (interrupts)
  );

  axi_read_engine i_axi_read_engine (
    .clock            (clock),
    .reset            (reset),
    .read_start       (read_start),
    .read_address     (read_address),
    .read_words       (read_words),
    .read_to_fifo     (read_to_fifo),
    .arready          (arready),
    .rdata            (rdata),
    .rvalid           (rvalid),
    .rlast            (rlast),
    .block_done       (block_done),
    .araddr           (araddr),
    .arlen            (arlen),
    .arvalid          (arvalid),
    .rready           (rready),
    .read_word_valid  (read_word_valid),
    .read_word        (read_word),
    .fifo_write_valid (fifo_write_valid),
    .fifo_write_data  (fifo_write_data),
    .start_write      (start_write),
    .read_done        (read_done)
  );

  axi_write_engine i_axi_write_engine (
    .clock             (clock),
    .reset             (reset),
    .write_start       (write_start),
    .write_address     (write_address),
    .write_words       (write_words),
    .fifo_word_written (fifo_word_written),
    .fifo_read_data    (fifo_read_data),
    .awready           (awready),
    .wready            (wready),
    .bvalid            (bvalid),
    .fifo_read_ready   (fifo_read_ready),
    .awaddr            (awaddr),
    .awlen             (awlen),
    .awvalid           (awvalid),
    .wdata             (wdata),
    .wvalid            (wvalid),
    .wlast             (wlast),
    .bready            (bready),
    .write_done        (write_done)
  );

endmodule

//--- source/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  write_start,
  input  adma_pkg::addr_t       write_address,
  input  adma_pkg::word_count_t write_words,
  input  logic                  fifo_word_written,
  input  adma_pkg::word_t       fifo_read_data,
  input  logic                  awready,
  input  logic                  wready,
  input  logic                  bvalid,
  output logic                  fifo_read_ready,
  output adma_pkg::addr_t       awaddr,
  output logic [7:0]            awlen,
  output logic                  awvalid,
  output adma_pkg::word_t       wdata,
  output logic                  wvalid,
  output logic                  wlast,
  output logic                  bready,
  output logic                  write_done
);

  import adma_pkg::*;

  write_state_t state;
  addr_t        address;
  word_count_t  remaining;
  word_count_t  available;
  beat_count_t  burst_len;
  beat_count_t  beat;

  beat_count_t  next_beats;
  logic         beat_accept;

  assign next_beats = (remaining >= word_count_t'(BURST_BEATS)) ? beat_count_t'(BURST_BEATS)
                                                                : beat_count_t'(remaining);

  assign awaddr      = address;
  assign awlen       = 8'(burst_len) - 8'd1;
  assign awvalid     = (state == WRITE_ADDRESS);
  assign wvalid      = (state == WRITE_DATA);
  assign wdata       = fifo_read_data;
  assign wlast       = wvalid && (beat == burst_len - 1'b1);
  assign beat_accept = wvalid && wready;
  assign bready      = (state == WRITE_RESPONSE);

  // Pop the FIFO head once the slave takes it
  assign fifo_read_ready = beat_accept;

  // Words pushed by the card and not yet sent
  always_ff @(posedge clock) begin
    if (!reset) begin
      available <= '0;
    end else begin
      case ({fifo_word_written, beat_accept})
        2'b10:   available <= available + 1'b1;
        2'b01:   available <= available - 1'b1;
        default: available <= available;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == WRITE_IDLE && write_start) begin
      address   <= write_address;
      remaining <= write_words;
    end else begin
      if (awvalid && awready) address <= address + addr_t'(BURST_BYTES);
      if (beat_accept) remaining <= remaining - 1'b1;
    end
    // Burst length is frozen before the address goes out
    if (state == WRITE_WAIT) begin
      burst_len <= next_beats;
      beat      <= '0;
    end else if (beat_accept) begin
      beat <= beat + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Write burst control
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= WRITE_IDLE;
      write_done <= 1'b0;
    end else begin
      write_done <= 1'b0;
      case (state)
        WRITE_IDLE:     if (write_start) state <= WRITE_WAIT;
        WRITE_WAIT:     if (available >= word_count_t'(next_beats)) state <= WRITE_ADDRESS;
        WRITE_ADDRESS:  if (awready) state <= WRITE_DATA;
        WRITE_DATA:     if (beat_accept && wlast) state <= WRITE_RESPONSE;
        WRITE_RESPONSE: begin
          if (bvalid) begin
            if (remaining == '0) begin
              write_done <= 1'b1;
              state      <= WRITE_IDLE;
            end else begin
              state <= WRITE_WAIT;
            end
          end
        end
        default: state <= WRITE_IDLE;
      endcase
    end
  end

endmodule

//--- source/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  read_start,
  input  adma_pkg::addr_t       read_address,
  input  adma_pkg::word_count_t read_words,
  input  logic                  read_to_fifo,
  input  logic                  arready,
  input  adma_pkg::word_t       rdata,
  input  logic                  rvalid,
  input  logic                  rlast,
  input  logic                  block_done,
  output adma_pkg::addr_t       araddr,
  output logic [7:0]            arlen,
  output logic                  arvalid,
  output logic                  rready,
  output logic                  read_word_valid,
  output adma_pkg::word_t       read_word,
  output logic                  fifo_write_valid,
  output adma_pkg::word_t       fifo_write_data,
  output logic                  start_write,
  output logic                  read_done
);

  import adma_pkg::*;

  localparam int BLOCK_COUNT_WIDTH = $clog2(BLOCK_WORDS);

  read_state_t                  state;
  addr_t                        address;
  word_count_t                  remaining;
  logic                         to_fifo;
  logic [BLOCK_COUNT_WIDTH-1:0] block_count;

  beat_count_t burst_beats;
  logic        beat_accept;
  logic        block_full;
  logic        final_word;

  assign burst_beats = (remaining >= word_count_t'(BURST_BEATS)) ? beat_count_t'(BURST_BEATS)
                                                                 : beat_count_t'(remaining);

  assign araddr  = address;
  assign arlen   = 8'(burst_beats) - 8'd1;
  assign arvalid = (state == READ_ADDRESS);
  assign rready  = (state == READ_DATA);

  // Beats go straight through to the sequencer or the card FIFO
  assign beat_accept      = rvalid && rready;
  assign read_word_valid  = beat_accept && !to_fifo;
  assign read_word        = rdata;
  assign fifo_write_valid = beat_accept && to_fifo;
  assign fifo_write_data  = rdata;

  assign block_full = (block_count == BLOCK_COUNT_WIDTH'(BLOCK_WORDS - 1));
  assign final_word = (remaining == word_count_t'(1));

  always_ff @(posedge clock) begin
    if (state == READ_IDLE && read_start) begin
      address     <= read_address;
      remaining   <= read_words;
      to_fifo     <= read_to_fifo;
      block_count <= '0;
    end else begin
      if (arvalid && arready) begin
        address <= address + addr_t'(BURST_BYTES);
      end
      if (beat_accept) begin
        remaining   <= remaining - 1'b1;
        block_count <= block_count + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Burst control and card pacing
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= READ_IDLE;
      start_write <= 1'b0;
      read_done   <= 1'b0;
    end else begin
      start_write <= 1'b0;
      read_done   <= 1'b0;
      case (state)
        READ_IDLE: begin
          if (read_start) state <= READ_ADDRESS;
        end
        READ_ADDRESS: begin
          if (arready) state <= READ_DATA;
        end
        READ_DATA: begin
          if (beat_accept && rlast) begin
            // Bursts never cross a block boundary, so blocks end on rlast
            if (to_fifo && (block_full || final_word)) begin
              start_write <= 1'b1;
              state       <= READ_BLOCK_WAIT;
            end else if (final_word) begin
              read_done <= 1'b1;
              state     <= READ_IDLE;
            end else begin
              state <= READ_ADDRESS;
            end
          end
        end
        READ_BLOCK_WAIT: begin
          if (block_done) begin
            if (remaining == '0) begin
              read_done <= 1'b1;
              state     <= READ_IDLE;
            end else begin
              state <= READ_ADDRESS;
            end
          end
        end
        default: state <= READ_IDLE;
      endcase
    end
  end

endmodule

//--- source/descriptor_sequencer.sv
`timescale 1ns/1ps

module descriptor_sequencer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dma_enable,
  input  logic                  direction,
  input  logic                  data_present,
  input  logic                  command_complete,
  input  logic                  interrupt_clear,
  input  adma_pkg::addr_t       descriptor_base,
  input  logic                  read_word_valid,
  input  adma_pkg::word_t       read_word,
  input  logic                  read_done,
  input  logic                  write_done,
  output logic                  read_start,
  output adma_pkg::addr_t       read_address,
  output adma_pkg::word_count_t read_words,
  output logic                  read_to_fifo,
  output logic                  write_start,
  output adma_pkg::addr_t       write_address,
  output adma_pkg::word_count_t write_words,
  output logic [1:0]            interrupts
);

  import adma_pkg::*;

  adma_state_t state;
  addr_t       pointer;
  descriptor_t line;

  logic        start_request;
  logic [1:0]  action;
  logic        last_line;
  logic        take_transfer;
  addr_t       line_address;
  addr_t       next_pointer;
  logic [15:0] length_field;
  byte_count_t line_bytes;
  word_count_t line_words;

  assign start_request = command_complete && dma_enable && data_present;
  assign action        = line[ACT_LSB +: 2];
  assign last_line     = line[END_BIT];
  assign line_address  = line[ADDRESS_LSB +: $bits(addr_t)];
  assign length_field  = line[LENGTH_LSB +: LENGTH_WIDTH];
  assign line_bytes    = (length_field == '0) ? {1'b1, 16'h0000} : {1'b0, length_field};
  assign line_words    = line_bytes[$bits(byte_count_t)-1:2];

  // A tran line shorter than one word moves nothing
  assign take_transfer = (action == ACT_TRAN) && (line_words != '0);

  // Nop, tran and reserved codes step to the next line
  always_comb begin
    case (action)
      ACT_LINK: next_pointer = line_address;
      default:  next_pointer = pointer + addr_t'(DESCRIPTOR_BYTES);
    endcase
  end

  // Request fields follow the state, the engines sample them with the start pulse
  assign read_address  = (state == ADMA_TRANSFER) ? line_address : pointer;
  assign read_words    = (state == ADMA_TRANSFER) ? line_words : word_count_t'(DESCRIPTOR_WORDS);
  assign read_to_fifo  = (state == ADMA_TRANSFER);
  assign write_address = line_address;
  assign write_words   = line_words;

  always_ff @(posedge clock) begin
    if (state == ADMA_STOP && start_request) begin
      pointer <= descriptor_base;
    end else if (state == ADMA_CHANGE_ADDRESS) begin
      pointer <= next_pointer;
    end
    // First word is the attribute half, second the address half
    if (read_word_valid) begin
      line <= {read_word, line[63:32]};
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // ADMA2 sequencer
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= ADMA_STOP;
      read_start  <= 1'b0;
      write_start <= 1'b0;
      interrupts  <= '0;
    end else begin
      read_start  <= 1'b0;
      write_start <= 1'b0;
      case (state)
        ADMA_STOP: begin
          if (start_request) begin
            state      <= ADMA_FETCH;
            read_start <= 1'b1;
          end
        end
        ADMA_FETCH: begin
          if (read_done) begin
            if (line[VALID_BIT]) begin
              state <= ADMA_CHANGE_ADDRESS;
            end else begin
              interrupts[1] <= 1'b1;
              state         <= ADMA_STOP;
            end
          end
        end
        ADMA_CHANGE_ADDRESS: begin
          if (take_transfer) begin
            state       <= ADMA_TRANSFER;
            read_start  <= !direction;
            write_start <= direction;
          end else if (last_line) begin
            interrupts[0] <= 1'b1;
            state         <= ADMA_STOP;
          end else begin
            state      <= ADMA_FETCH;
            read_start <= 1'b1;
          end
        end
        ADMA_TRANSFER: begin
          if (read_done || write_done) begin
            if (last_line) begin
              interrupts[0] <= 1'b1;
              state         <= ADMA_STOP;
            end else begin
              state      <= ADMA_FETCH;
              read_start <= 1'b1;
            end
          end
        end
        default: state <= ADMA_STOP;
      endcase
      if (interrupt_clear) begin
        interrupts <= '0;
      end
    end
  end

endmodule

//--- source/adma_pkg.sv
package adma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [63:0] descriptor_t;

  // Descriptor length, a zero length field stands for 65536 bytes
  typedef logic [16:0] byte_count_t;
  typedef logic [14:0] word_count_t;
  typedef logic [4:0]  beat_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // Burst and block sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int BURST_BEATS      = 16;
  localparam int BURST_BYTES      = 64;
  localparam int BLOCK_WORDS      = 128;
  localparam int DESCRIPTOR_BYTES = 8;
  localparam int DESCRIPTOR_WORDS = 2;

  // Descriptor line fields
  localparam int VALID_BIT    = 0;
  localparam int END_BIT      = 1;
  localparam int ACT_LSB      = 4;
  localparam int LENGTH_LSB   = 16;
  localparam int LENGTH_WIDTH = 16;
  localparam int ADDRESS_LSB  = 32;

  localparam logic [1:0] ACT_NOP  = 2'b00;
  localparam logic [1:0] ACT_TRAN = 2'b10;
  localparam logic [1:0] ACT_LINK = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ADMA_STOP,
    ADMA_FETCH,
    ADMA_CHANGE_ADDRESS,
    ADMA_TRANSFER
  } adma_state_t;

  typedef enum logic [1:0] {
    READ_IDLE,
    READ_ADDRESS,
    READ_DATA,
    READ_BLOCK_WAIT
  } read_state_t;

  typedef enum logic [2:0] {
    WRITE_IDLE,
    WRITE_WAIT,
    WRITE_ADDRESS,
    WRITE_DATA,
    WRITE_RESPONSE
  } write_state_t;

endpackage
